/* include/input_params.svh */
/*
 * Player count, joystick widths, button layout and input polarity
 */
`ifndef INPUT_PARAMS_SVH
`define INPUT_PARAMS_SVH

// Player and keyboard counts
`define INPUT_PLAYERS       4
`define INPUT_KEY_PLAYERS   3

// Joystick widths on the board side and the game side
`define INPUT_BOARD_W       16
`define INPUT_GAME_W        10
`define INPUT_BUTTONS       2

// Board joystick bits that follow the buttons
`define INPUT_START_BIT     (6 + (`INPUT_BUTTONS - 2))
`define INPUT_COIN_BIT      (7 + (`INPUT_BUTTONS - 2))
`define INPUT_PAUSE_BIT     (8 + (`INPUT_BUTTONS - 2))

`define INPUT_GFX_LAYERS    4

// Game inputs are inverted when set
`define INPUT_ACTIVE_LOW    1

`endif

/* rtl/joy_pkg.sv */
/*
 * Joystick types: remembered direction, board joystick word,
 * all-player board bus and the game-side input bundle
 */
`default_nettype none

`include "input_params.svh"

package joy_pkg;

    // Direction held by the 4-way filter
    typedef enum logic [2:0] {
        dir_none,
        dir_right,
        dir_left,
        dir_down,
        dir_up
    } joy_dir_e;

    // Direction bits: 0 right, 1 left, 2 down, 3 up
    typedef struct packed {
        logic [`INPUT_BOARD_W-5:0] upper;
        logic [3:0]                dir;
    } board_joy_t;

    // Element 0 is player 1
    typedef board_joy_t [`INPUT_PLAYERS-1:0] board_joy_arr_t;

    typedef struct packed {
        logic [`INPUT_PLAYERS-1:0][`INPUT_GAME_W-1:0] joy;
        logic [`INPUT_PLAYERS-1:0]                    coin;
        logic [`INPUT_PLAYERS-1:0]                    start;
    } game_in_t;

endpackage

`default_nettype wire

/* rtl/ctrl_pkg.sv */
/*
 * Keyboard and control types: decoded key bus, pause state,
 * control levels and game control outputs
 */
`default_nettype none

`include "input_params.svh"

package ctrl_pkg;

    typedef struct packed {
        logic [`INPUT_KEY_PLAYERS-1:0][`INPUT_GAME_W-1:0] key_joy;
        logic [`INPUT_PLAYERS-1:0]                        key_coin;
        logic [`INPUT_PLAYERS-1:0]                        key_start;
        logic [`INPUT_GFX_LAYERS-1:0]                     key_gfx;
        logic                                             key_pause;
        logic                                             key_reset;
        logic                                             key_service;
    } key_bus_t;

    typedef enum logic {
        run,
        paused
    } pause_e;

    typedef struct packed {
        logic four_way;
        logic rot;
        logic flip;
        logic downloading;
        logic osd_pause;
    } ctrl_lvl_t;

    typedef struct packed {
        logic                         game_pause;
        logic                         soft_rst;
        logic                         game_service;
        logic [`INPUT_GFX_LAYERS-1:0] gfx_en;
    } game_ctrl_t;

endpackage

`default_nettype wire

/* rtl/input_capture.sv */
/*
 * Input register stage for board joysticks, keys and control levels
 */
`default_nettype none

module input_capture (
    input  wire                          clk_sys,
    input  wire                          rst,
    input  wire joy_pkg::board_joy_arr_t board_joy_in,
    input  wire ctrl_pkg::key_bus_t      keys_in,
    input  wire ctrl_pkg::ctrl_lvl_t     ctrl_in,
    output joy_pkg::board_joy_arr_t      board_joy_q,
    output ctrl_pkg::key_bus_t           keys_q,
    output ctrl_pkg::ctrl_lvl_t          ctrl_q
);
    import joy_pkg::*;
    import ctrl_pkg::*;

    // Board and keyboard levels arrive from other clock domains.
    // Everything downstream samples from this single register
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            board_joy_q <= '0;
            keys_q      <= '0;
            ctrl_q      <= '0;
        end else begin
            board_joy_q <= board_joy_in;
            keys_q      <= keys_in;
            ctrl_q      <= ctrl_in;
        end
    end

endmodule

`default_nettype wire

/* rtl/joy_4way_filter.sv */
/*
 * Per-player 4-way direction filter; upper joystick bits,
 * keys and control levels are delayed alongside
 */
`default_nettype none

`include "input_params.svh"

module joy_4way_filter (
    input  wire                          clk_sys,
    input  wire                          rst,
    input  wire joy_pkg::board_joy_arr_t board_joy_in,
    input  wire ctrl_pkg::key_bus_t      keys_in,
    input  wire ctrl_pkg::ctrl_lvl_t     ctrl_in,
    output joy_pkg::board_joy_arr_t      board_joy_q,
    output ctrl_pkg::key_bus_t           keys_q,
    output ctrl_pkg::ctrl_lvl_t          ctrl_q
);
    import joy_pkg::*;
    import ctrl_pkg::*;

    joy_dir_e   dir_q   [`INPUT_PLAYERS];
    joy_dir_e   dir_d   [`INPUT_PLAYERS];
    logic [3:0] dir_out [`INPUT_PLAYERS];

    // Single pressed direction, none for idle or diagonals
    function automatic joy_dir_e bits_to_dir(input logic [3:0] bits);
        case (bits)
            4'b0001: return dir_right;
            4'b0010: return dir_left;
            4'b0100: return dir_down;
            4'b1000: return dir_up;
            default: return dir_none;
        endcase
    endfunction

    function automatic logic [3:0] dir_to_bits(input joy_dir_e dir);
        case (dir)
            dir_right: return 4'b0001;
            dir_left:  return 4'b0010;
            dir_down:  return 4'b0100;
            dir_up:    return 4'b1000;
            default:   return 4'b0000;
        endcase
    endfunction

    always_comb begin
        for (int p = 0; p < `INPUT_PLAYERS; p++) begin
            logic [3:0] bits;
            logic       multi;
            bits  = board_joy_in[p].dir;
            multi = (bits & (bits - 4'd1)) != 4'd0;
            if (ctrl_in.four_way && multi) begin
                // Diagonal: stay on the last single direction
                dir_out[p] = dir_to_bits(dir_q[p]);
                dir_d[p]   = dir_q[p];
            end else begin
                dir_out[p] = bits;
                dir_d[p]   = bits_to_dir(bits);
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            for (int p = 0; p < `INPUT_PLAYERS; p++) begin
                dir_q[p] <= dir_none;
            end
            board_joy_q <= '0;
            keys_q      <= '0;
            ctrl_q      <= '0;
        end else begin
            for (int p = 0; p < `INPUT_PLAYERS; p++) begin
                dir_q[p]             <= dir_d[p];
                board_joy_q[p].upper <= board_joy_in[p].upper;
                board_joy_q[p].dir   <= dir_out[p];
            end
            keys_q <= keys_in;
            ctrl_q <= ctrl_in;
        end
    end

endmodule

`default_nettype wire

/* rtl/joy_map.sv */
/*
 * Game joystick builder: key merge, screen rotation, coin and
 * start collection, polarity inversion
 */
`default_nettype none

`include "input_params.svh"

module joy_map (
    input  wire                          clk_sys,
    input  wire                          rst,
    input  wire joy_pkg::board_joy_arr_t board_joy_in,
    input  wire ctrl_pkg::key_bus_t      keys_in,
    input  wire ctrl_pkg::ctrl_lvl_t     ctrl_in,
    output joy_pkg::game_in_t            game_in
);
    import joy_pkg::*;
    import ctrl_pkg::*;

    localparam int game_in_w = $bits(game_in_t);
    localparam logic [game_in_w-1:0] inv_mask = {game_in_w{1'(`INPUT_ACTIVE_LOW)}};

    logic [`INPUT_PLAYERS-1:0][`INPUT_GAME_W-1:0] key_joy_ext;
    game_in_t                                     merged;

    // Only the direction nibble moves with the screen
    function automatic logic [`INPUT_GAME_W-1:0] rotate_dirs(
        input logic [`INPUT_GAME_W-1:0] joy,
        input logic                     rot,
        input logic                     flip
    );
        logic [3:0] d;
        d = joy[3:0];
        if (rot) begin
            if (flip) begin
                d = {joy[1], joy[0], joy[2], joy[3]};
            end else begin
                d = {joy[0], joy[1], joy[3], joy[2]};
            end
        end
        return {joy[`INPUT_GAME_W-1:4], d};
    endfunction

    // Players without keyboard directions see zero keys
    always_comb begin
        key_joy_ext = '0;
        for (int k = 0; k < `INPUT_KEY_PLAYERS; k++) begin
            key_joy_ext[k] = keys_in.key_joy[k];
        end
    end

    always_comb begin
        for (int p = 0; p < `INPUT_PLAYERS; p++) begin
            logic [`INPUT_BOARD_W-1:0] raw;
            raw = board_joy_in[p];
            merged.joy[p] = rotate_dirs(raw[`INPUT_GAME_W-1:0] | key_joy_ext[p],
                                        ctrl_in.rot, ctrl_in.flip);
            merged.coin[p]  = raw[`INPUT_COIN_BIT] | keys_in.key_coin[p];
            merged.start[p] = raw[`INPUT_START_BIT] | keys_in.key_start[p];
        end
    end

    // Reset loads the inverted idle value
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            game_in <= game_in_t'(inv_mask);
        end else begin
            game_in <= game_in_t'(merged ^ inv_mask);
        end
    end

endmodule

`default_nettype wire

/* rtl/game_ctrl.sv */
/*
 * Pause state, soft-reset pulse, graphics layer toggles and service
 */
`default_nettype none

`include "input_params.svh"

module game_ctrl (
    input  wire                          clk_sys,
    input  wire                          rst,
    input  wire joy_pkg::board_joy_arr_t board_joy_in,
    input  wire ctrl_pkg::key_bus_t      keys_in,
    input  wire ctrl_pkg::ctrl_lvl_t     ctrl_in,
    output ctrl_pkg::game_ctrl_t         game_ctl
);
    import joy_pkg::*;
    import ctrl_pkg::*;

    pause_e                       pause_st;
    pause_e                       pause_nx;
    logic                         soft_rst_q;
    logic                         service_q;
    logic [`INPUT_GFX_LAYERS-1:0] gfx_en_q;

    // Previous levels for edge detection
    logic                         prev_key_pause;
    logic                         prev_joy_pause;
    logic                         prev_osd_pause;
    logic                         prev_key_reset;
    logic [`INPUT_GFX_LAYERS-1:0] prev_key_gfx;

    logic [`INPUT_BOARD_W-1:0]    joy1_raw;
    logic [`INPUT_BOARD_W-1:0]    joy2_raw;
    logic                         joy_pause;
    logic                         pause_rise;

    assign joy1_raw = board_joy_in[0];
    assign joy2_raw = board_joy_in[1];

    // Either of the first two players can pause
    assign joy_pause  = joy1_raw[`INPUT_PAUSE_BIT] | joy2_raw[`INPUT_PAUSE_BIT];
    assign pause_rise = (keys_in.key_pause && !prev_key_pause)
                      || (joy_pause && !prev_joy_pause);

    always_comb begin
        pause_nx = pause_st;
        if (ctrl_in.downloading) begin
            pause_nx = run;
        end else if (ctrl_in.osd_pause != prev_osd_pause) begin
            // OSD menu overrides the toggle
            pause_nx = ctrl_in.osd_pause ? paused : run;
        end else if (pause_rise) begin
            pause_nx = (pause_st == run) ? paused : run;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            pause_st       <= run;
            soft_rst_q     <= 1'b0;
            service_q      <= 1'(`INPUT_ACTIVE_LOW);
            gfx_en_q       <= '1;
            prev_key_pause <= 1'b0;
            prev_joy_pause <= 1'b0;
            prev_osd_pause <= 1'b0;
            prev_key_reset <= 1'b0;
            prev_key_gfx   <= '0;
        end else begin
            pause_st       <= pause_nx;
            soft_rst_q     <= keys_in.key_reset && !prev_key_reset;
            service_q      <= keys_in.key_service ^ 1'(`INPUT_ACTIVE_LOW);
            gfx_en_q       <= gfx_en_q ^ (keys_in.key_gfx & ~prev_key_gfx);
            prev_key_pause <= keys_in.key_pause;
            prev_joy_pause <= joy_pause;
            prev_osd_pause <= ctrl_in.osd_pause;
            prev_key_reset <= keys_in.key_reset;
            prev_key_gfx   <= keys_in.key_gfx;
        end
    end

    assign game_ctl = '{
        game_pause:   (pause_st == paused),
        soft_rst:     soft_rst_q,
        game_service: service_q,
        gfx_en:       gfx_en_q
    };

endmodule

`default_nettype wire

/* rtl/input_board.sv */
/*
 * Player input path: capture, 4-way filter, then joystick
 * mapping and game control side by side
 */
`default_nettype none

module input_board (
    input  wire                          clk_sys,
    input  wire                          rst,
    input  wire joy_pkg::board_joy_arr_t board_joy,
    input  wire ctrl_pkg::key_bus_t      keys,
    input  wire ctrl_pkg::ctrl_lvl_t     ctrl,
    output wire joy_pkg::game_in_t       game_in,
    output wire ctrl_pkg::game_ctrl_t    game_ctl
);
    import joy_pkg::*;
    import ctrl_pkg::*;

    // Capture stage outputs
    wire board_joy_arr_t cap_joy;
    wire key_bus_t       cap_keys;
    wire ctrl_lvl_t      cap_ctrl;

    // Filter stage outputs
    wire board_joy_arr_t flt_joy;
    wire key_bus_t       flt_keys;
    wire ctrl_lvl_t      flt_ctrl;

    input_capture u_capture (
        .clk_sys      (clk_sys),
        .rst          (rst),
        .board_joy_in (board_joy),
        .keys_in      (keys),
        .ctrl_in      (ctrl),
        .board_joy_q  (cap_joy),
        .keys_q       (cap_keys),
        .ctrl_q       (cap_ctrl)
    );

    joy_4way_filter u_filter (
        .clk_sys      (clk_sys),
        .rst          (rst),
        .board_joy_in (cap_joy),
        .keys_in      (cap_keys),
        .ctrl_in      (cap_ctrl),
        .board_joy_q  (flt_joy),
        .keys_q       (flt_keys),
        .ctrl_q       (flt_ctrl)
    );

    // Last stage splits into two parallel blocks
    joy_map u_map (
        .clk_sys      (clk_sys),
        .rst          (rst),
        .board_joy_in (flt_joy),
        .keys_in      (flt_keys),
        .ctrl_in      (flt_ctrl),
        .game_in      (game_in)
    );

    game_ctrl u_ctrl (
        .clk_sys      (clk_sys),
        .rst          (rst),
        .board_joy_in (flt_joy),
        .keys_in      (flt_keys),
        .ctrl_in      (flt_ctrl),
        .game_ctl     (game_ctl)
    );

endmodule

`default_nettype wire

/* tb/tb_input_board.sv */
/*
 * Random-stimulus testbench for the input path, with a reference
 * model, a 3-deep expected-value delay line and per-test results
 */
`default_nettype none

`include "input_params.svh"

module tb_input_board;
    import joy_pkg::*;
    import ctrl_pkg::*;

    // Cycles per test
    localparam int n_reset = 8;
    localparam int n_pass  = 200;
    localparam int n_four  = 200;
    localparam int n_rot   = 100;
    localparam int n_pause = 300;
    localparam int n_gfx   = 200;
    localparam int n_drain = 3;
    localparam int timeout_limit = 4 + n_reset + n_pass + n_four + 2 * n_rot
                                 + n_pause + n_gfx + 6 * n_drain + 50;

    logic            clk_sys;
    logic            rst;
    board_joy_arr_t  board_joy;
    key_bus_t        keys;
    ctrl_lvl_t       ctrl;
    wire game_in_t   game_in;
    wire game_ctrl_t game_ctl;

    integer seed;
    int     errors;
    int     checks;
    int     tests_run;
    int     tests_passed;
    int     cycles;

    // Expected outputs, one entry per input still in flight
    logic [$bits(game_in_t)-1:0]   exp_in_q[$];
    logic [$bits(game_ctrl_t)-1:0] exp_ctl_q[$];

    // Model state
    logic [3:0]                   m_dir [`INPUT_PLAYERS];
    logic                         m_pause;
    logic                         m_prev_kp;
    logic                         m_prev_jp;
    logic                         m_prev_osd;
    logic                         m_prev_kr;
    logic [`INPUT_GFX_LAYERS-1:0] m_prev_gfx;
    logic [`INPUT_GFX_LAYERS-1:0] m_gfx;

    input_board DUT (
        .clk_sys   (clk_sys),
        .rst       (rst),
        .board_joy (board_joy),
        .keys      (keys),
        .ctrl      (ctrl),
        .game_in   (game_in),
        .game_ctl  (game_ctl)
    );

    always #2 clk_sys = ~clk_sys;

    always @(posedge clk_sys) begin
        cycles++;
        if (cycles > timeout_limit) begin
            $display("Timeout: run went past %0d cycles", timeout_limit);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic compare_value(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("CHECK FAILED %s expected 0x%0h actual 0x%0h", name, expected, actual);
            errors++;
        end
    endtask

    function automatic game_in_t reset_game_in();
        game_in_t gi;
        gi = `INPUT_ACTIVE_LOW ? '1 : '0;
        return gi;
    endfunction

    function automatic game_ctrl_t reset_game_ctl();
        game_ctrl_t gc;
        gc.game_pause   = 1'b0;
        gc.soft_rst     = 1'b0;
        gc.game_service = 1'(`INPUT_ACTIVE_LOW);
        gc.gfx_en       = '1;
        return gc;
    endfunction

    // Whole pipeline collapsed into one step per input
    task automatic model_cycle(input board_joy_arr_t bj, input key_bus_t k,
                               input ctrl_lvl_t c, output game_in_t gi,
                               output game_ctrl_t gc);
        logic [3:0]                d;
        logic [3:0]                r;
        logic [`INPUT_BOARD_W-1:0] raw;
        logic [`INPUT_BOARD_W-1:0] raw0;
        logic [`INPUT_BOARD_W-1:0] raw1;
        logic [`INPUT_GAME_W-1:0]  j;
        logic                      jp;
        for (int p = 0; p < `INPUT_PLAYERS; p++) begin
            d = bj[p].dir;
            if (c.four_way && $countones(d) >= 2) begin
                d = m_dir[p];
            end else begin
                m_dir[p] = ($countones(d) == 1) ? d : 4'b0000;
            end
            raw = {bj[p].upper, d};
            j   = raw[`INPUT_GAME_W-1:0];
            if (p < `INPUT_KEY_PLAYERS) begin
                j = j | k.key_joy[p];
            end
            r = j[3:0];
            if (c.rot && !c.flip) begin
                r = {j[0], j[1], j[3], j[2]};
            end else if (c.rot) begin
                r = {j[1], j[0], j[2], j[3]};
            end
            gi.joy[p]   = {j[`INPUT_GAME_W-1:4], r};
            gi.coin[p]  = raw[`INPUT_COIN_BIT] | k.key_coin[p];
            gi.start[p] = raw[`INPUT_START_BIT] | k.key_start[p];
        end
        if (`INPUT_ACTIVE_LOW) begin
            gi = ~gi;
        end
        raw0 = bj[0];
        raw1 = bj[1];
        jp   = raw0[`INPUT_PAUSE_BIT] | raw1[`INPUT_PAUSE_BIT];
        if (c.downloading) begin
            m_pause = 1'b0;
        end else if (c.osd_pause != m_prev_osd) begin
            m_pause = c.osd_pause;
        end else if ((k.key_pause && !m_prev_kp) || (jp && !m_prev_jp)) begin
            m_pause = !m_pause;
        end
        m_gfx           = m_gfx ^ (k.key_gfx & ~m_prev_gfx);
        gc.game_pause   = m_pause;
        gc.soft_rst     = k.key_reset && !m_prev_kr;
        gc.game_service = k.key_service ^ 1'(`INPUT_ACTIVE_LOW);
        gc.gfx_en       = m_gfx;
        m_prev_kp  = k.key_pause;
        m_prev_jp  = jp;
        m_prev_osd = c.osd_pause;
        m_prev_kr  = k.key_reset;
        m_prev_gfx = k.key_gfx;
    endtask

    // Check the oldest expectation, then drive the next input
    task automatic step(input board_joy_arr_t bj, input key_bus_t k, input ctrl_lvl_t c);
        game_in_t   exp_gi;
        game_ctrl_t exp_gc;
        game_in_t   gi;
        game_ctrl_t gc;
        @(negedge clk_sys);
        exp_gi = exp_in_q.pop_front();
        exp_gc = exp_ctl_q.pop_front();
        compare_value("game_in", exp_gi, game_in);
        compare_value("game_pause", exp_gc.game_pause, game_ctl.game_pause);
        compare_value("soft_rst", exp_gc.soft_rst, game_ctl.soft_rst);
        compare_value("game_service", exp_gc.game_service, game_ctl.game_service);
        compare_value("gfx_en", exp_gc.gfx_en, game_ctl.gfx_en);
        model_cycle(bj, k, c, gi, gc);
        exp_in_q.push_back(gi);
        exp_ctl_q.push_back(gc);
        board_joy = bj;
        keys      = k;
        ctrl      = c;
    endtask

    task automatic random_stimulus(output board_joy_arr_t bj, output key_bus_t k);
        logic [63:0] r;
        bj = {$random(seed), $random(seed)};
        r  = {$random(seed), $random(seed)};
        k  = r[$bits(key_bus_t)-1:0];
    endtask

    // Hold the last inputs until the delay line has caught up
    task automatic drain_pipeline();
        repeat (n_drain) step(board_joy, keys, ctrl);
    endtask

    task automatic report_test(input string name, input int err_start);
        tests_run++;
        if (errors == err_start) begin
            tests_passed++;
            $display("%s: pass", name);
        end else begin
            $display("%s: %0d errors", name, errors - err_start);
        end
    endtask

    task automatic run_random(input int n, input logic four_way, input logic rot,
                              input logic flip);
        board_joy_arr_t bj;
        key_bus_t       k;
        ctrl_lvl_t      c;
        c = '0;
        c.four_way = four_way;
        c.rot      = rot;
        c.flip     = flip;
        for (int i = 0; i < n; i++) begin
            random_stimulus(bj, k);
            step(bj, k, c);
        end
        drain_pipeline();
    endtask

    task automatic run_pause(input int n);
        board_joy_arr_t bj;
        key_bus_t       k;
        ctrl_lvl_t      c;
        c = '0;
        for (int i = 0; i < n; i++) begin
            random_stimulus(bj, k);
            // Rare OSD changes and short download bursts
            if (($random(seed) & 7) == 0) begin
                c.osd_pause = !c.osd_pause;
            end
            c.downloading = (($random(seed) & 15) == 0);
            step(bj, k, c);
        end
        drain_pipeline();
    endtask

    initial begin
        game_in_t   rst_gi;
        game_ctrl_t rst_gc;
        int         err_start;
        seed      = 32'h2875_84c6;
        clk_sys   = 1'b0;
        rst       = 1'b1;
        // Busy inputs during reset must not leak into the pipeline
        random_stimulus(board_joy, keys);
        ctrl      = '0;
        errors    = 0;
        checks    = 0;
        cycles    = 0;
        tests_run    = 0;
        tests_passed = 0;
        for (int p = 0; p < `INPUT_PLAYERS; p++) begin
            m_dir[p] = 4'b0000;
        end
        m_pause    = 1'b0;
        m_prev_kp  = 1'b0;
        m_prev_jp  = 1'b0;
        m_prev_osd = 1'b0;
        m_prev_kr  = 1'b0;
        m_prev_gfx = '0;
        m_gfx      = '1;
        rst_gi = reset_game_in();
        rst_gc = reset_game_ctl();
        repeat (3) exp_in_q.push_back(rst_gi);
        repeat (3) exp_ctl_q.push_back(rst_gc);

        repeat (3) @(posedge clk_sys);
        @(negedge clk_sys);
        rst       = 1'b0;
        board_joy = '0;
        keys      = '0;

        // Reset values on the first cycle out of reset
        err_start = errors;
        @(negedge clk_sys);
        compare_value("game_in", rst_gi, game_in);
        compare_value("game_pause", 1'b0, game_ctl.game_pause);
        compare_value("soft_rst", 1'b0, game_ctl.soft_rst);
        compare_value("gfx_en", {`INPUT_GFX_LAYERS{1'b1}}, game_ctl.gfx_en);
        compare_value("game_service", 1'b1, game_ctl.game_service);
        repeat (n_reset) step('0, '0, '0);
        report_test("reset values", err_start);

        err_start = errors;
        run_random(n_pass, 1'b0, 1'b0, 1'b0);
        report_test("pass-through", err_start);

        err_start = errors;
        run_random(n_four, 1'b1, 1'b0, 1'b0);
        report_test("4-way filter", err_start);

        err_start = errors;
        run_random(n_rot, 1'b0, 1'b1, 1'b0);
        run_random(n_rot, 1'b0, 1'b1, 1'b1);
        report_test("rotation", err_start);

        err_start = errors;
        run_pause(n_pause);
        report_test("pause", err_start);

        err_start = errors;
        run_random(n_gfx, 1'b0, 1'b0, 1'b0);
        report_test("soft reset and graphics", err_start);

        $display("Summary: %0d of %0d tests passed, %0d checks, %0d errors",
                 tests_passed, tests_run, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+include
rtl/joy_pkg.sv
rtl/ctrl_pkg.sv
rtl/input_capture.sv
rtl/joy_4way_filter.sv
rtl/joy_map.sv
rtl/game_ctrl.sv
rtl/input_board.sv
tb/tb_input_board.sv
